//--- Makefile
TOP := memorySystemTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+verification
verilog/cachePkg.sv
verilog/dcacheTags.sv
verilog/dcacheData.sv
verilog/dcacheCtrl.sv
verilog/dataMemory.sv
verilog/memorySystem.sv
verification/memorySystemTb.sv

//--- verification/memorySystemChecks.svh
`ifndef MEMORY_SYSTEM_CHECKS_SVH
`define MEMORY_SYSTEM_CHECKS_SVH

// Included inside memorySystemTb and calls its endInFailure task

task automatic checkWord(input word_t got, input word_t exp, input string what);
	if (got !== exp)
	begin
		$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		endInFailure();
	end
endtask

task automatic checkAddr(input word_t got, input word_t exp, input string what);
	if (got !== exp)
	begin
		$display("MISMATCH at %0t ns: %s, address %h, expected %h", $time, what, got, exp);
		endInFailure();
	end
endtask

// Single-bit results such as dhit timing
task automatic checkBit(input logic got, input logic exp, input string what);
	if (got !== exp)
	begin
		$display("MISMATCH at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
		endInFailure();
	end
endtask

task automatic complain(input string why);
	$display("ERROR at %0t ns: %s", $time, why);
	endInFailure();
endtask

`endif

//--- verification/memorySystemTb.sv
`timescale 1ns/10ps

module memorySystemTb import cachePkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int MEM_LATENCY = 2;
	localparam int ITERATIONS = 150;
	// Worst case is three requests per iteration
	localparam int REQUESTS = 3 * ITERATIONS;
	localparam int REQ_LIMIT = 4 * (MEM_LATENCY + 1) + 2;
	localparam int FLUSH_LIMIT = 16 * (2 * (MEM_LATENCY + 1) + 2) + 4;
	localparam int WATCHDOG_CYCLES = REQUESTS * REQ_LIMIT + 16 * 2 * (MEM_LATENCY + 1) + 100;

	logic CLK, rstN, halt, dmemREN, dmemWEN;
	word_t dmemaddr, dmemstore, dmemload, daddr, dstore;
	logic dhit, flushDone, dREN, dWEN, dwait;

	word_t model [MEM_WORDS];
	// Blocks written by the datapath and not yet written back
	logic dirtyBlk [MEM_WORDS / 2];
	word_t pool [24];
	int seed;
	int busyCycles;
	logic wbHalf;
	word_t wbBlock;

	memorySystem #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) dut0 (
		.CLK(CLK), .rstN(rstN), .halt(halt), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
		.dmemaddr(dmemaddr), .dmemstore(dmemstore), .dhit(dhit), .dmemload(dmemload),
		.flushed(flushDone), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
		.dwait(dwait)
	);

	task automatic endInFailure();
		$display(">>> FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	`include "memorySystemChecks.svh"

	// Four sets, three tags each, both words of every block
	function automatic word_t poolAddr(input int p);
		int slot;
		int k;
		slot = p / 6;
		k = (p % 6) / 2;
		return word_t'((((k * 5 + slot) % 16) << 6)
			| (((slot * 3 + 1) % 8) << 3) | ((p % 2) << 2));
	endfunction

	// Holds one request until dhit and checks it against the model
	task automatic runRequest(input logic isWrite, input word_t addr, input word_t data,
		output int cycles);
		cycles = 0;
		@(negedge CLK);
		dmemREN = !isWrite;
		dmemWEN = isWrite;
		dmemaddr = addr;
		dmemstore = data;
		do
		begin
			@(posedge CLK);
			cycles++;
			if (!dhit && cycles >= REQ_LIMIT)
				complain($sformatf("request to %h got no dhit", addr));
		end
		while (!dhit);
		if (isWrite)
		begin
			model[addr[9:2]] = data;
			dirtyBlk[addr[9:3]] = 1'b1;
		end
		else
			checkWord(dmemload, model[addr[9:2]], $sformatf("read of %h", addr));
	endtask

	// Write-backs come as two words of a dirty block with the lowest word first
	task automatic checkWriteBack();
		if (daddr >= 32'd1024)
			complain($sformatf("write-back to %h outside the tested range", daddr));
		checkWord(dstore, model[daddr[9:2]], $sformatf("write-back data at %h", daddr));
		if (!wbHalf)
		begin
			checkAddr(daddr, {daddr[31:3], 3'b000}, "first write-back word");
			if (!dirtyBlk[daddr[9:3]])
				complain($sformatf("clean block at %h was written back", daddr));
			wbBlock = daddr;
			wbHalf = 1'b1;
		end
		else
		begin
			checkAddr(daddr, wbBlock + 32'd4, "second write-back word");
			dirtyBlk[daddr[9:3]] = 1'b0;
			wbHalf = 1'b0;
		end
	endtask

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Memory bus monitor
	always @(posedge CLK)
	begin
		if (rstN)
		begin
			if (dREN || dWEN)
			begin
				if (flushDone)
					complain("memory bus request after flushed");
				if (dREN && (halt || wbHalf))
					complain("memory read during a write-back");
				if (dwait)
					busyCycles++;
				else
				begin
					checkWord(word_t'(busyCycles), word_t'(MEM_LATENCY), "wait cycles of a word");
					busyCycles = 0;
					if (dWEN)
						checkWriteBack();
				end
			end
			else if (dwait || busyCycles != 0)
				complain("memory request dropped or dwait high while the bus is idle");
		end
	end

	initial
	begin
		cacheState_t stuckState;
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		stuckState = dut0.ctrl0.state;
		complain($sformatf("run hung before completion, controller in %s", stuckState.name()));
	end

	initial
	begin
		int choice;
		int pick;
		int other;
		int cycles;
		word_t data;
		rstN = 1'b0;
		halt = 1'b0;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		dmemaddr = '0;
		dmemstore = '0;
		seed = 32'ha1a406ec;
		busyCycles = 0;
		wbHalf = 1'b0;
		wbBlock = '0;
		// Memory comes out of reset holding each word's byte address
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			model[i] = 4 * i;
			dirtyBlk[i / 2] = 1'b0;
		end
		for (int p = 0; p < 24; p++)
			pool[p] = poolAddr(p);
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;

		for (int i = 0; i < ITERATIONS; i++)
		begin
			choice = $unsigned($random(seed)) % 4;
			pick = $unsigned($random(seed)) % 24;
			data = $random(seed);
			case (choice)
				0, 1:
					runRequest(1'b0, pool[pick], '0, cycles);
				2:
				begin
					runRequest(1'b1, pool[pick], data, cycles);
					runRequest(1'b0, pool[pick], '0, cycles);
				end
				default:
				begin
					// Next tag of the same set and word
					other = (pick / 6) * 6 + (((pick % 6) / 2 + 1) % 3) * 2 + pick % 2;
					runRequest(1'b0, pool[pick], '0, cycles);
					runRequest(data[0], pool[other], data, cycles);
					runRequest(1'b0, pool[pick], '0, cycles);
					checkBit(cycles == 1, 1'b1, "re-read hit after touching the other way");
				end
			endcase
		end

		@(negedge CLK);
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		halt = 1'b1;
		cycles = 0;
		while (!flushDone)
		begin
			@(posedge CLK);
			cycles++;
			if (cycles > FLUSH_LIMIT)
				complain("flushed did not rise after halt");
		end
		for (int b = 0; b < MEM_WORDS / 2; b++)
		begin
			if (dirtyBlk[b])
				complain($sformatf("block at %h still dirty when flushed rose", b * 8));
		end
		// Monitor keeps watching for bus requests after flushed
		repeat (8) @(posedge CLK);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- verilog/cachePkg.sv
package cachePkg;

	// Datapath word, also used for byte addresses
	typedef logic [31:0] word_t;

	// Address split: tag | set index | block offset | byte offset
	localparam int TAG_W = 26;
	localparam int IDX_W = 3;
	localparam int SETS = 8;

	// Controller states
	typedef enum logic [2:0] {
		idle,
		writeBack0,
		writeBack1,
		fetch0,
		fetch1,
		flushScan,
		flushed
	} cacheState_t;

	function automatic logic [TAG_W-1:0] addrTag(word_t addr);
		return addr[31:32-TAG_W];
	endfunction

	function automatic logic [IDX_W-1:0] addrIdx(word_t addr);
		return addr[IDX_W+2:3];
	endfunction

	// Word within the two-word block
	function automatic logic addrWord(word_t addr);
		return addr[2];
	endfunction

	// Rebuild a byte address from its fields
	function automatic word_t blockAddr(logic [TAG_W-1:0] tag, logic [IDX_W-1:0] idx,
		logic wordSel);
		return {tag, idx, wordSel, 2'b00};
	endfunction

endpackage

//--- verilog/dataMemory.sv
`timescale 1ns/10ps

module dataMemory import cachePkg::*;
#(
	parameter int MEM_WORDS = 256,
	parameter int MEM_LATENCY = 2
)
(
	input logic CLK,
	input logic rstN,
	input logic dREN,
	input logic dWEN,
	input word_t daddr,
	input word_t dstore,
	output logic dwait,
	output word_t dload
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int CW = (MEM_LATENCY > 0) ? $clog2(MEM_LATENCY + 1) : 1;

	word_t mem [MEM_WORDS];

	logic [CW-1:0] waitCnt;
	logic busy;
	logic done;
	logic [AW-1:0] wordIdx;

	assign busy = dREN || dWEN;
	assign wordIdx = daddr[AW+1:2];

	// Last cycle of a held request
	assign done = busy && (waitCnt == CW'(MEM_LATENCY));
	assign dwait = busy && !done;
	assign dload = mem[wordIdx];

	always_ff @(posedge CLK)
	begin
		if (!rstN)
			waitCnt <= '0;
		else if (done || !busy)
			waitCnt <= '0;
		else
			waitCnt <= waitCnt + 1'b1;
	end

	// Reset image holds each word's own byte address
	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= word_t'(i) << 2;
		end
		else if (dWEN && done)
		begin
			mem[wordIdx] <= dstore;
		end
	end

	assert property (@(posedge CLK) disable iff (!rstN) dwait |=> $stable(daddr))
		else $error("daddr changed during wait states");

endmodule

//--- verilog/dcacheCtrl.sv
`timescale 1ns/10ps

module dcacheCtrl import cachePkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic dmemREN,
	input logic dmemWEN,
	input logic halt,
	input word_t dmemaddr,
	input logic hit,
	input logic hitWay,
	input logic victimWay,
	input logic victimDirty,
	input logic [TAG_W-1:0] victimTag,
	input logic lineDirty,
	input logic [TAG_W-1:0] lineTag,
	input word_t evictData,
	input logic dwait,
	input word_t dload,
	output logic dhit,
	output logic writeHit,
	output logic fillEn,
	output logic fillWay,
	output logic fillWordSel,
	output logic cleanEn,
	output logic cleanWay,
	output logic [IDX_W-1:0] cleanIdx,
	output logic dREN,
	output logic dWEN,
	output word_t daddr,
	output word_t dstore,
	output word_t fillData,
	output logic flushed
);

	cacheState_t state;
	cacheState_t nextState;
	// State whose bus request is driven this cycle
	cacheState_t effState;

	logic flushing;
	logic [IDX_W:0] scanCnt;
	logic scanLast;
	logic missWay;
	logic request;
	logic [IDX_W-1:0] reqIdx;
	logic [TAG_W-1:0] wbTag;

	assign request = dmemREN || dmemWEN;
	assign reqIdx = addrIdx(dmemaddr);
	assign scanLast = &scanCnt;

	// A miss seen in idle starts its first bus word in the same cycle
	always_comb
	begin
		effState = state;
		if (state == idle && !halt && request && !hit)
			effState = victimDirty ? writeBack0 : fetch0;
	end

	assign dhit = (state == idle) && !halt && request && hit;
	assign writeHit = dhit && dmemWEN;

	assign dREN = (effState == fetch0) || (effState == fetch1);
	assign dWEN = (effState == writeBack0) || (effState == writeBack1);
	assign fillWordSel = (effState == fetch1) || (effState == writeBack1);
	assign fillEn = dREN && !dwait;
	assign fillData = dload;
	assign dstore = evictData;

	// Scan counter holds the index in its high bits and the way in its low bit
	assign cleanIdx = flushing ? scanCnt[IDX_W:1] : reqIdx;
	assign cleanWay = scanCnt[0];
	assign cleanEn = flushing && (state == writeBack1) && !dwait;
	assign flushed = (state == cachePkg::flushed);

	// Way seen by the data store
	always_comb
	begin
		if (flushing)
			fillWay = cleanWay;
		else if (state == idle)
			fillWay = hit ? hitWay : victimWay;
		else
			fillWay = missWay;
	end

	assign wbTag = flushing ? lineTag : victimTag;
	assign daddr = dWEN ? blockAddr(wbTag, cleanIdx, fillWordSel)
		: blockAddr(addrTag(dmemaddr), reqIdx, fillWordSel);

	always_comb
	begin
		nextState = effState;
		case (effState)
			idle:
				if (halt)
					nextState = flushScan;
			writeBack0:
				if (!dwait)
					nextState = writeBack1;
			writeBack1:
				if (!dwait)
					nextState = flushing ? flushScan : fetch0;
			fetch0:
				if (!dwait)
					nextState = fetch1;
			fetch1:
				if (!dwait)
					nextState = idle;
			flushScan:
				if (lineDirty)
					nextState = writeBack0;
				else if (scanLast)
					nextState = cachePkg::flushed;
			default:
				nextState = effState;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			state <= idle;
			flushing <= 1'b0;
			scanCnt <= '0;
			missWay <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// Hold the victim for the whole miss
			if (state == idle && effState != idle)
				missWay <= victimWay;
			if (state == idle && halt)
				flushing <= 1'b1;
			// A written-back line comes back clean and the scan moves on
			if (state == flushScan && !lineDirty && !scanLast)
				scanCnt <= scanCnt + 1'b1;
		end
	end

	// The datapath keeps its request and address until the miss is served
	assert property (@(posedge CLK) disable iff (!rstN)
		(state != idle && !flushing) |-> request && $stable(dmemaddr))
		else $error("request dropped or changed during a miss in %s", state.name());

endmodule

//--- verilog/dcacheData.sv
`timescale 1ns/10ps

module dcacheData import cachePkg::*;
(
	input logic CLK,
	input logic rstN,
	input word_t reqAddr,
	input logic way,
	input logic wordSel,
	input logic writeEn,
	input word_t writeData,
	input logic fillEn,
	input logic fillWordSel,
	input word_t fillData,
	input logic [IDX_W-1:0] portIdx,
	output word_t readData,
	output word_t evictData
);

	// Set, way, word
	word_t store [SETS][2][2];

	logic [IDX_W-1:0] reqIdx;
	logic reqWord;

	assign reqIdx = addrIdx(reqAddr);
	assign reqWord = addrWord(reqAddr);

	// Datapath read, way is the hit way while idle
	assign readData = store[reqIdx][way][reqWord];

	// Write-back read, shared by miss eviction and flush
	assign evictData = store[portIdx][way][wordSel];

	always_ff @(posedge CLK)
	begin
		// No writes while held in reset
		if (rstN)
		begin
			if (fillEn)
			begin
				store[reqIdx][way][fillWordSel] <= fillData;
			end
			else if (writeEn)
			begin
				store[reqIdx][way][reqWord] <= writeData;
			end
		end
	end

endmodule

//--- verilog/dcacheTags.sv
`timescale 1ns/10ps

module dcacheTags import cachePkg::*;
(
	input logic CLK,
	input logic rstN,
	input word_t reqAddr,
	input logic fillEn,
	input logic fillWay,
	input logic writeHit,
	input logic cleanEn,
	input logic [IDX_W-1:0] cleanIdx,
	input logic cleanWay,
	output logic hit,
	output logic hitWay,
	output logic victimWay,
	output logic victimDirty,
	output logic [TAG_W-1:0] victimTag,
	output logic lineDirty,
	output logic [TAG_W-1:0] lineTag
);

	logic [TAG_W-1:0] tagMem [SETS][2];
	logic [1:0] valid [SETS];
	logic [1:0] dirty [SETS];
	// One bit per set, names the way to evict next
	logic [SETS-1:0] lru;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [1:0] match;

	assign idx = addrIdx(reqAddr);
	assign tag = addrTag(reqAddr);

	assign match[0] = valid[idx][0] && (tagMem[idx][0] == tag);
	assign match[1] = valid[idx][1] && (tagMem[idx][1] == tag);

	assign hit = |match;
	assign hitWay = match[1];

	// Victim is always the LRU way; an empty way is never behind a valid one here
	assign victimWay = lru[idx];
	assign victimDirty = valid[idx][victimWay] && dirty[idx][victimWay];
	assign victimTag = tagMem[idx][victimWay];

	// Flush port, looks at one line at a time
	assign lineDirty = valid[cleanIdx][cleanWay] && dirty[cleanIdx][cleanWay];
	assign lineTag = tagMem[cleanIdx][cleanWay];

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			for (int s = 0; s < SETS; s++)
			begin
				valid[s] <= '0;
				dirty[s] <= '0;
			end
			lru <= '0;
		end
		else
		begin
			if (fillEn)
			begin
				valid[idx][fillWay] <= 1'b1;
				dirty[idx][fillWay] <= 1'b0;
			end
			if (writeHit)
				dirty[idx][hitWay] <= 1'b1;
			if (cleanEn)
				dirty[cleanIdx][cleanWay] <= 1'b0;
			// Other way becomes the next victim
			if (hit)
				lru[idx] <= ~hitWay;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fillEn)
			tagMem[idx][fillWay] <= tag;
	end

	// A fill only happens on a miss, so a tag can live in one way only
	assert property (@(posedge CLK) disable iff (!rstN) !(match[0] && match[1]))
		else $error("tag %h hits in both ways of set %0d", tag, idx);

endmodule

//--- verilog/memorySystem.sv
`timescale 1ns/10ps

module memorySystem import cachePkg::*;
#(
	parameter int MEM_WORDS = 256,
	parameter int MEM_LATENCY = 2
)
(
	input logic CLK,
	input logic rstN,
	input logic halt,
	input logic dmemREN,
	input logic dmemWEN,
	input word_t dmemaddr,
	input word_t dmemstore,
	output logic dhit,
	output word_t dmemload,
	output logic flushed,
	output logic dREN,
	output logic dWEN,
	output word_t daddr,
	output word_t dstore,
	output logic dwait
);

	logic hit, hitWay, victimWay, victimDirty, lineDirty;
	logic [TAG_W-1:0] victimTag;
	logic [TAG_W-1:0] lineTag;
	logic writeHit, fillEn, fillWay, fillWordSel, cleanEn, cleanWay;
	logic [IDX_W-1:0] cleanIdx;
	word_t fillData;
	word_t evictData;
	word_t dload;

	dcacheTags tags0 (
		.CLK(CLK), .rstN(rstN), .reqAddr(dmemaddr),
		.fillEn(fillEn), .fillWay(fillWay), .writeHit(writeHit),
		.cleanEn(cleanEn), .cleanIdx(cleanIdx), .cleanWay(cleanWay),
		.hit(hit), .hitWay(hitWay), .victimWay(victimWay), .victimDirty(victimDirty),
		.victimTag(victimTag), .lineDirty(lineDirty), .lineTag(lineTag)
	);

	// Word select is shared by the fill and the write-back
	dcacheData data0 (
		.CLK(CLK), .rstN(rstN), .reqAddr(dmemaddr), .way(fillWay),
		.wordSel(fillWordSel), .writeEn(writeHit), .writeData(dmemstore),
		.fillEn(fillEn), .fillWordSel(fillWordSel), .fillData(fillData),
		.portIdx(cleanIdx), .readData(dmemload), .evictData(evictData)
	);

	dcacheCtrl ctrl0 (
		.CLK(CLK), .rstN(rstN), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
		.dmemaddr(dmemaddr), .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
		.victimDirty(victimDirty), .victimTag(victimTag), .lineDirty(lineDirty),
		.lineTag(lineTag), .evictData(evictData), .dwait(dwait), .dload(dload),
		.dhit(dhit), .writeHit(writeHit), .fillEn(fillEn), .fillWay(fillWay),
		.fillWordSel(fillWordSel), .cleanEn(cleanEn), .cleanWay(cleanWay),
		.cleanIdx(cleanIdx), .dREN(dREN), .dWEN(dWEN), .daddr(daddr),
		.dstore(dstore), .fillData(fillData), .flushed(flushed)
	);

	dataMemory #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) mem0 (
		.CLK(CLK), .rstN(rstN), .dREN(dREN), .dWEN(dWEN),
		.daddr(daddr), .dstore(dstore), .dwait(dwait), .dload(dload)
	);

endmodule
